// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	////////////////////
	// Word widths
	////////////////////

	// CPU address
	typedef logic [15:0] mem_addr_t;

	// Memory data word
	typedef logic [15:0] mem_value_t;

	// Program counter value
	typedef logic [15:0] reg_value_t;

	// Separates repeated accesses from one instruction
	typedef logic [31:0] act_id_t;

	// Serial byte
	typedef logic [7:0] byte_t;

	////////////////////
	// Address map
	////////////////////

	localparam mem_addr_t UART_DATA_ADDR   = 16'hBF00;
	localparam mem_addr_t UART_STATUS_ADDR = 16'hBF01;

	// Low address bits decoded inside a bank
	localparam int BANK_ADDR_BITS = 8;

	// Bank wait states and serial bit time
	localparam int RAM1_WAIT     = 2;
	localparam int RAM2_WAIT     = 3;
	localparam int UART_BAUD_DIV = 16;

	////////////////////
	// State encodings
	////////////////////

	typedef enum logic [1:0] {
		BANK_IDLE,
		BANK_BUSY,
		BANK_DONE
	} bank_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

// ==== hdl/ram_bank.sv ====
module ram_bank #(
	parameter int WAIT_STATES = 2
) (
	input  logic                               ram1_work_done,
	input  logic                               rst_n,
	input  logic                               need_to_work,
	input  logic                               wr,
	input  logic [mem_pkg::BANK_ADDR_BITS-1:0] addr,
	input  mem_pkg::mem_value_t                wdata,
	output logic                               done,
	output mem_pkg::mem_value_t                rdata
);

	localparam int DEPTH = 1 << mem_pkg::BANK_ADDR_BITS;
	localparam int CNT_W = $clog2(WAIT_STATES + 1);

	mem_pkg::bank_state_t state;
	mem_pkg::bank_state_t state_next;
	logic [CNT_W-1:0]     wait_cnt;
	logic                 last_wait;
	logic                 finish;

	mem_pkg::mem_value_t  mem [DEPTH];

	assign last_wait = (wait_cnt == CNT_W'(WAIT_STATES - 1));

	// Final wait cycle, the access happens on this edge
	assign finish = (state == mem_pkg::BANK_BUSY) && last_wait;

	assign done = (state == mem_pkg::BANK_DONE);

	////////////////////
	// Bank FSM
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			mem_pkg::BANK_IDLE,
			mem_pkg::BANK_DONE: begin
				if (need_to_work) begin
					state_next = mem_pkg::BANK_BUSY;
				end
			end
			mem_pkg::BANK_BUSY: begin
				if (last_wait) begin
					state_next = mem_pkg::BANK_DONE;
				end
			end
			default: begin
				state_next = mem_pkg::BANK_IDLE;
			end
		endcase
	end

	always_ff @(posedge ram1_work_done or negedge rst_n) begin
		if (!rst_n) begin
			state    <= mem_pkg::BANK_IDLE;
			wait_cnt <= '0;
		end else begin
			state <= state_next;
			// Count restarts on every new start
			if (state != mem_pkg::BANK_BUSY) begin
				wait_cnt <= '0;
			end else if (!last_wait) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (finish && wr) begin
			mem[addr] <= wdata;
		end
	end

	// Held until the next access ends
	always_ff @(posedge ram1_work_done) begin
		if (finish) begin
			if (wr) begin
				rdata <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== hdl/uart_rx.sv ====
module uart_rx #(
	parameter int BAUD_DIV = mem_pkg::UART_BAUD_DIV
) (
	input  logic           ram1_work_done,
	input  logic           rst_n,
	input  logic           uart_rxd,
	input  logic           byte_taken,
	output mem_pkg::byte_t rx_byte,
	output logic           received,
	output logic           reading
);

	localparam int CNT_W = $clog2(BAUD_DIV);

	mem_pkg::rx_state_t state;
	logic [1:0]         rxd_sync;
	logic               rxd;
	logic [CNT_W-1:0]   baud_cnt;
	logic [2:0]         bit_idx;
	mem_pkg::byte_t     shift;
	logic               half_bit;
	logic               full_bit;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge ram1_work_done or negedge rst_n) begin
		if (!rst_n) begin
			rxd_sync <= 2'b11;
		end else begin
			rxd_sync <= {rxd_sync[0], uart_rxd};
		end
	end

	assign rxd      = rxd_sync[1];
	assign half_bit = (baud_cnt == CNT_W'(BAUD_DIV / 2 - 1));
	assign full_bit = (baud_cnt == CNT_W'(BAUD_DIV - 1));
	assign reading  = (state != mem_pkg::RX_IDLE);

	////////////////////
	// Receive FSM
	////////////////////

	always_ff @(posedge ram1_work_done or negedge rst_n) begin
		if (!rst_n) begin
			state    <= mem_pkg::RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			received <= 1'b0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
			if (byte_taken) begin
				received <= 1'b0;
			end
			case (state)
				mem_pkg::RX_IDLE: begin
					baud_cnt <= '0;
					if (!rxd) begin
						state <= mem_pkg::RX_START;
					end
				end
				mem_pkg::RX_START: begin
					// Recheck at mid start bit, glitches fall back to idle
					if (half_bit) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rxd ? mem_pkg::RX_IDLE : mem_pkg::RX_DATA;
					end
				end
				mem_pkg::RX_DATA: begin
					if (full_bit) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= mem_pkg::RX_STOP;
						end
					end
				end
				mem_pkg::RX_STOP: begin
					if (full_bit) begin
						state <= mem_pkg::RX_IDLE;
						// A new byte wins over a same-cycle take
						if (rxd) begin
							received <= 1'b1;
						end
					end
				end
				default: begin
					state <= mem_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge ram1_work_done) begin
		if (state == mem_pkg::RX_DATA && full_bit) begin
			shift <= {rxd, shift[7:1]};
		end
		if (state == mem_pkg::RX_STOP && full_bit && rxd) begin
			rx_byte <= shift;
		end
	end

endmodule

// ==== hdl/ram_controller.sv ====
module ram_controller (
	input  logic                                 ram1_work_done,
	input  logic                                 rst_n,
	input  logic                                 mem_rd,
	input  logic                                 mem_wr,
	input  mem_pkg::mem_addr_t                   addr,
	input  mem_pkg::mem_value_t                  wdata,
	input  mem_pkg::reg_value_t                  pc,
	input  mem_pkg::act_id_t                     mem_act,
	input  logic                                 bank1_done,
	input  logic                                 bank2_done,
	input  mem_pkg::mem_value_t                  bank1_rdata,
	input  mem_pkg::mem_value_t                  bank2_rdata,
	input  mem_pkg::byte_t                       rx_byte,
	input  logic                                 received,
	input  logic                                 reading,
	output logic                                 bank1_need_to_work,
	output logic                                 bank2_need_to_work,
	output logic                                 bank_wr,
	output logic [mem_pkg::BANK_ADDR_BITS-1:0]   bank_addr,
	output mem_pkg::mem_value_t                  bank_wdata,
	output logic                                 work_done,
	output mem_pkg::mem_value_t                  feedback,
	output logic                                 byte_taken
);

	logic                req;
	logic                is_uart_data;
	logic                is_uart_status;
	logic                is_bank1;
	logic                data_rd;
	logic [1:0]          done_in;
	logic [1:0]          done_q;
	logic [1:0]          done_rise;
	logic [1:0]          bank_hit;
	mem_pkg::reg_value_t tag_pc [2];
	mem_pkg::act_id_t    tag_act [2];
	logic                taken_valid;
	mem_pkg::reg_value_t taken_pc;
	mem_pkg::act_id_t    taken_act;

	assign req            = mem_rd | mem_wr;
	assign is_uart_data   = (addr == mem_pkg::UART_DATA_ADDR);
	assign is_uart_status = (addr == mem_pkg::UART_STATUS_ADDR);
	assign is_bank1       = addr[15];

	// Shared bank request lines, held by the CPU
	assign bank_wr    = mem_wr;
	assign bank_addr  = addr[mem_pkg::BANK_ADDR_BITS-1:0];
	assign bank_wdata = wdata;

	////////////////////
	// Completion tags
	////////////////////

	assign done_in   = {bank2_done, bank1_done};
	assign done_rise = done_in & ~done_q;

	// On the rise cycle the held request is the one that started the bank
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			bank_hit[i] = done_in[i] &&
				(done_rise[i] || (tag_pc[i] == pc && tag_act[i] == mem_act));
		end
	end

	always_ff @(posedge ram1_work_done or negedge rst_n) begin
		if (!rst_n) begin
			done_q <= '0;
			for (int i = 0; i < 2; i++) begin
				tag_pc[i]  <= '0;
				tag_act[i] <= '0;
			end
		end else begin
			done_q <= done_in;
			for (int i = 0; i < 2; i++) begin
				if (done_rise[i]) begin
					tag_pc[i]  <= pc;
					tag_act[i] <= mem_act;
				end
			end
		end
	end

	////////////////////
	// Request routing
	////////////////////

	always_comb begin
		bank1_need_to_work = 1'b0;
		bank2_need_to_work = 1'b0;
		work_done          = 1'b1;
		feedback           = '0;
		if (req) begin
			if (is_uart_status) begin
				feedback = {{14{1'b1}}, received, ~reading};
			end else if (is_uart_data) begin
				feedback = mem_pkg::mem_value_t'(rx_byte);
			end else if (is_bank1) begin
				work_done          = bank_hit[0];
				bank1_need_to_work = ~bank_hit[0];
				feedback           = bank1_rdata;
			end else begin
				work_done          = bank_hit[1];
				bank2_need_to_work = ~bank_hit[1];
				feedback           = bank2_rdata;
			end
		end
	end

	// Byte consumed once per distinct data read
	assign data_rd    = mem_rd & is_uart_data;
	assign byte_taken = data_rd &&
		!(taken_valid && taken_pc == pc && taken_act == mem_act);

	always_ff @(posedge ram1_work_done or negedge rst_n) begin
		if (!rst_n) begin
			taken_valid <= 1'b0;
			taken_pc    <= '0;
			taken_act   <= '0;
		end else if (data_rd) begin
			taken_valid <= 1'b1;
			taken_pc    <= pc;
			taken_act   <= mem_act;
		end
	end

endmodule

// ==== hdl/mem_subsystem.sv ====
module mem_subsystem (
	input  logic                ram1_work_done,
	input  logic                rst_n,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  mem_pkg::mem_addr_t  addr,
	input  mem_pkg::mem_value_t wdata,
	input  mem_pkg::reg_value_t pc,
	input  mem_pkg::act_id_t    mem_act,
	input  logic                uart_rxd,
	output logic                work_done,
	output mem_pkg::mem_value_t feedback
);

	logic                               bank1_need_to_work;
	logic                               bank2_need_to_work;
	logic                               bank_wr;
	logic [mem_pkg::BANK_ADDR_BITS-1:0] bank_addr;
	mem_pkg::mem_value_t                bank_wdata;
	logic                               bank1_done;
	logic                               bank2_done;
	mem_pkg::mem_value_t                bank1_rdata;
	mem_pkg::mem_value_t                bank2_rdata;
	mem_pkg::byte_t                     rx_byte;
	logic                               received;
	logic                               reading;
	logic                               byte_taken;

	ram_controller u_ctrl (
		.ram1_work_done     (ram1_work_done),
		.rst_n              (rst_n),
		.mem_rd             (mem_rd),
		.mem_wr             (mem_wr),
		.addr               (addr),
		.wdata              (wdata),
		.pc                 (pc),
		.mem_act            (mem_act),
		.bank1_done         (bank1_done),
		.bank2_done         (bank2_done),
		.bank1_rdata        (bank1_rdata),
		.bank2_rdata        (bank2_rdata),
		.rx_byte            (rx_byte),
		.received           (received),
		.reading            (reading),
		.bank1_need_to_work (bank1_need_to_work),
		.bank2_need_to_work (bank2_need_to_work),
		.bank_wr            (bank_wr),
		.bank_addr          (bank_addr),
		.bank_wdata         (bank_wdata),
		.work_done          (work_done),
		.feedback           (feedback),
		.byte_taken         (byte_taken)
	);

	// Bit 15 set
	ram_bank #(.WAIT_STATES(mem_pkg::RAM1_WAIT)) u_bank1 (
		.ram1_work_done (ram1_work_done),
		.rst_n          (rst_n),
		.need_to_work   (bank1_need_to_work),
		.wr             (bank_wr),
		.addr           (bank_addr),
		.wdata          (bank_wdata),
		.done           (bank1_done),
		.rdata          (bank1_rdata)
	);

	ram_bank #(.WAIT_STATES(mem_pkg::RAM2_WAIT)) u_bank2 (
		.ram1_work_done (ram1_work_done),
		.rst_n          (rst_n),
		.need_to_work   (bank2_need_to_work),
		.wr             (bank_wr),
		.addr           (bank_addr),
		.wdata          (bank_wdata),
		.done           (bank2_done),
		.rdata          (bank2_rdata)
	);

	uart_rx #(.BAUD_DIV(mem_pkg::UART_BAUD_DIV)) u_rx (
		.ram1_work_done (ram1_work_done),
		.rst_n          (rst_n),
		.uart_rxd       (uart_rxd),
		.byte_taken     (byte_taken),
		.rx_byte        (rx_byte),
		.received       (received),
		.reading        (reading)
	);

endmodule

// ==== testbench/mem_props.sv ====
module mem_props (
	input logic                ram1_work_done,
	input logic                rst_n,
	input logic                mem_rd,
	input logic                mem_wr,
	input mem_pkg::mem_addr_t  addr,
	input mem_pkg::reg_value_t pc,
	input mem_pkg::act_id_t    mem_act,
	input logic                bank1_need_to_work,
	input logic                bank2_need_to_work,
	input logic                work_done,
	input logic                byte_taken,
	input logic                received,
	input logic                reading
);

	timeunit 1ns;
	timeprecision 1ps;

	logic req;
	logic uart_addr;

	assign req       = mem_rd | mem_wr;
	assign uart_addr = (addr == mem_pkg::UART_DATA_ADDR) ||
		(addr == mem_pkg::UART_STATUS_ADDR);

	// No bank is started while the CPU is idle
	idle_no_bank: assert property (@(posedge ram1_work_done) disable iff (!rst_n)
		!req |-> (!bank1_need_to_work && !bank2_need_to_work))
		else $error("bank request line asserted with no CPU request");

	// A stale done level from the last access never completes a new one
	new_bank_req_waits: assert property (@(posedge ram1_work_done) disable iff (!rst_n)
		(req && !uart_addr && ($changed(pc) || $changed(mem_act))) |-> !work_done)
		else $error("bank request completed in the cycle it was issued");

	// Flag clears after a take while the receiver is idle
	take_clears_received: assert property (@(posedge ram1_work_done) disable iff (!rst_n)
		(byte_taken && !reading) |=> !received)
		else $error("received still set after byte_taken");

endmodule

// ==== testbench/mem_checker.sv ====
module mem_checker (
	input  logic                ram1_work_done,
	input  logic                rst_n,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  mem_pkg::mem_addr_t  addr,
	input  logic                work_done,
	input  mem_pkg::mem_value_t feedback,
	input  mem_pkg::mem_value_t exp_value,
	output int                  error_count,
	output int                  check_count
);

	timeunit 1ns;
	timeprecision 1ps;

	int errs = 0;
	int checks = 0;

	assign error_count = errs;
	assign check_count = checks;

	// Outputs are settled at the falling edge, inputs move on the rising one
	always @(negedge ram1_work_done) begin
		if (!mem_rd && !mem_wr) begin
			if (work_done !== 1'b1) begin
				$display("ERR t=%0t work_done exp=1 got=%b", $time, work_done);
				errs++;
			end
		end else if (rst_n && mem_rd && work_done === 1'b1) begin
			// A read completes here exactly once before the next request
			checks++;
			if (feedback !== exp_value) begin
				$display("ERR t=%0t feedback (addr %h) exp=%h got=%h",
					$time, addr, exp_value, feedback);
				errs++;
			end
		end
	end

endmodule

// ==== testbench/tb_mem_subsystem.sv ====
module tb_mem_subsystem;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int         REQ_TIMEOUT = 64;
	localparam logic [3:0] OP_READ     = 4'h1;
	localparam logic [3:0] OP_WRITE    = 4'h2;
	localparam logic [3:0] OP_SERIAL   = 4'h3;
	localparam string      TRACE_FILE  = "testbench/mem_trace.txt";

	logic                ram1_work_done = 1'b0;
	logic                rst_n;
	logic                mem_rd;
	logic                mem_wr;
	mem_pkg::mem_addr_t  addr;
	mem_pkg::mem_value_t wdata;
	mem_pkg::reg_value_t pc;
	mem_pkg::act_id_t    mem_act;
	logic                uart_rxd;
	logic                work_done;
	mem_pkg::mem_value_t feedback;
	mem_pkg::mem_value_t exp_value;
	int                  error_count;
	int                  check_count;
	int                  timeouts = 0;
	int                  setup_fail = 0;
	int                  reads_issued = 0;

	mem_subsystem u_dut (
		.ram1_work_done (ram1_work_done),
		.rst_n          (rst_n),
		.mem_rd         (mem_rd),
		.mem_wr         (mem_wr),
		.addr           (addr),
		.wdata          (wdata),
		.pc             (pc),
		.mem_act        (mem_act),
		.uart_rxd       (uart_rxd),
		.work_done      (work_done),
		.feedback       (feedback)
	);

	mem_checker u_check (
		.ram1_work_done (ram1_work_done),
		.rst_n          (rst_n),
		.mem_rd         (mem_rd),
		.mem_wr         (mem_wr),
		.addr           (addr),
		.work_done      (work_done),
		.feedback       (feedback),
		.exp_value      (exp_value),
		.error_count    (error_count),
		.check_count    (check_count)
	);

	bind ram_controller mem_props u_props (
		.ram1_work_done     (ram1_work_done),
		.rst_n              (rst_n),
		.mem_rd             (mem_rd),
		.mem_wr             (mem_wr),
		.addr               (addr),
		.pc                 (pc),
		.mem_act            (mem_act),
		.bank1_need_to_work (bank1_need_to_work),
		.bank2_need_to_work (bank2_need_to_work),
		.work_done          (work_done),
		.byte_taken         (byte_taken),
		.received           (received),
		.reading            (reading)
	);

	initial begin
		forever #20 ram1_work_done = ~ram1_work_done;
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	// Start bit, eight data bits LSB first, stop bit
	task automatic send_serial(input mem_pkg::byte_t value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rxd <= frame[i];
			repeat (mem_pkg::UART_BAUD_DIV) @(posedge ram1_work_done);
		end
	endtask

	task automatic wait_done(input int line_no);
		int cycles;
		cycles = 0;
		@(negedge ram1_work_done);
		while (!work_done && cycles < REQ_TIMEOUT) begin
			@(negedge ram1_work_done);
			cycles++;
		end
		if (!work_done) begin
			$display("Timeout: request on trace line %0d not done after %0d cycles",
				line_no, REQ_TIMEOUT);
			timeouts++;
		end
	endtask

	task automatic apply_line(
		input logic [3:0]          op,
		input mem_pkg::mem_addr_t  a,
		input mem_pkg::mem_value_t d,
		input mem_pkg::reg_value_t p,
		input mem_pkg::act_id_t    act,
		input mem_pkg::mem_value_t e,
		input int                  line_no
	);
		@(posedge ram1_work_done);
		mem_rd    <= (op == OP_READ);
		mem_wr    <= (op == OP_WRITE);
		addr      <= a;
		wdata     <= d;
		pc        <= p;
		mem_act   <= act;
		exp_value <= e;
		if (op == OP_READ) begin
			reads_issued++;
		end
		// The CPU side stays idle while a byte arrives
		if (op == OP_SERIAL) begin
			send_serial(mem_pkg::byte_t'(d));
		end else begin
			wait_done(line_no);
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int                  fd;
		int                  n;
		int                  line_no;
		string               line;
		logic [3:0]          op;
		mem_pkg::mem_addr_t  a;
		mem_pkg::mem_value_t d;
		mem_pkg::reg_value_t p;
		mem_pkg::act_id_t    act;
		mem_pkg::mem_value_t e;

		rst_n     = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		addr      = '0;
		wdata     = '0;
		pc        = '0;
		mem_act   = '0;
		uart_rxd  = 1'b1;
		exp_value = '0;
		repeat (16) @(posedge ram1_work_done);
		rst_n <= 1'b1;

		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open trace file %s", TRACE_FILE);
			setup_fail++;
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				line_no++;
				// Comment and empty lines carry no request
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%h %h %h %h %h %h", op, a, d, p, act, e) == 6) begin
						apply_line(op, a, d, p, act, e, line_no);
					end else begin
						$display("Trace line %0d could not be parsed", line_no);
						setup_fail++;
					end
				end
			end
			$fclose(fd);
		end

		@(posedge ram1_work_done);
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		wait_done(0);

		if (check_count != reads_issued) begin
			$display("Checker saw %0d read completions but %0d reads were issued",
				check_count, reads_issued);
			setup_fail++;
		end
		$display("Summary: %0d reads checked, %0d errors, %0d timeouts",
			check_count, error_count + setup_fail, timeouts);
		if (error_count + setup_fail + timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== testbench/mem_trace.txt ====
# op addr wdata pc act expected, all in hex
# op 0 idle, 1 read, 2 write, 3 serial byte taken from wdata
0 0000 0000 0000 00000000 0000
2 8010 1234 0010 00000001 0000
1 8010 0000 0012 00000002 1234
2 0010 5678 0014 00000003 0000
1 0010 0000 0016 00000004 5678
1 8010 0000 0018 00000005 1234
0 0000 0000 0000 00000000 0000
2 8020 aaaa 001c 00000006 0000
1 8020 0000 0020 00000007 aaaa
2 8020 bbbb 0024 00000008 0000
1 8020 0000 0020 00000009 bbbb
2 0020 1111 0030 0000000a 0000
1 0020 0000 0034 0000000b 1111
2 0020 2222 0038 0000000c 0000
1 0020 0000 0034 0000000d 2222
1 8010 0000 0040 0000000e 1234
1 8010 0000 0042 0000000f 1234
2 80ff cafe 0044 00000010 0000
2 00ff beef 0046 00000011 0000
1 80ff 0000 0048 00000012 cafe
1 00ff 0000 004a 00000013 beef
0 0000 0000 0000 00000000 0000
1 bf01 0000 0050 00000014 fffd
3 0000 005a 0000 00000000 0000
1 bf01 0000 0052 00000015 ffff
1 bf00 0000 0054 00000016 005a
1 bf01 0000 0056 00000017 fffd
3 0000 00c3 0000 00000000 0000
1 bf01 0000 0058 00000018 ffff
1 bf00 0000 005a 00000019 00c3
1 bf01 0000 005c 0000001a fffd
0 0000 0000 0000 00000000 0000

// ==== sim.f ====
hdl/mem_pkg.sv
hdl/ram_bank.sv
hdl/uart_rx.sv
hdl/ram_controller.sv
hdl/mem_subsystem.sv
testbench/mem_props.sv
testbench/mem_checker.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
